// ==== Bender.yml ====
package:
  name: mips_mem

sources:
  - include_dirs:
      - include
    files:
      - source/mips_pkg.sv
      - source/cache_bus_if.sv
      - source/mem_bus_if.sv
      - source/instr_decoder.sv
      - source/cache_ctrl.sv
      - source/data_cache.sv
      - source/main_memory.sv
      - source/mips_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_mips_mem.sv

// ==== include/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath word
`define MIPS_DATA_W 32

// 16 lines of one word each
`define MIPS_CACHE_IDX_W 4

// backing store
`define MIPS_MEM_WORDS 256
`define MIPS_MEM_LAT 4
`define MIPS_MEM_FILL 32'h1000_0000

`endif

// ==== sim.f ====
+incdir+include
source/mips_pkg.sv
source/cache_bus_if.sv
source/mem_bus_if.sv
source/instr_decoder.sv
source/cache_ctrl.sv
source/data_cache.sv
source/main_memory.sv
source/mips_mem_top.sv
verif/tb_mips_mem.sv

// ==== source/cache_bus_if.sv ====
`timescale 1ns/1ns

interface cache_bus_if;
    logic we;         // line write on this edge
    logic set_dirty;
    logic fill_sel;   // 1 picks store data over memory rdata
    logic hit;
    logic dirty;      // indexed line valid and dirty

    modport ctrl (
        output we,
        output set_dirty,
        output fill_sel,
        input  hit,
        input  dirty
    );

    modport cache (
        input  we,
        input  set_dirty,
        input  fill_sel,
        output hit,
        output dirty
    );
endinterface

// ==== source/cache_ctrl.sv ====
`timescale 1ns/1ns

module cache_ctrl import mips_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  ctrl_t        ctrl,
    cache_bus_if.ctrl    cbus,
    mem_bus_if.ctrl      mbus,
    output logic         pc_enable,
    output logic         reg_write
);

    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_refill,
        st_update
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   req_q;
    logic   req_d;
    logic   victim_dirty;

    // a miss that must evict a modified line first
    assign victim_dirty = cbus.dirty && !cbus.hit;

    always_comb begin
        state_d        = state_q;
        req_d          = req_q;
        pc_enable      = 1'b0;
        reg_write      = 1'b0;
        cbus.we        = 1'b0;
        cbus.set_dirty = 1'b0;
        cbus.fill_sel  = 1'b0;

        case (state_q)
            st_idle: begin
                if (ctrl.is_load) begin
                    if (cbus.hit) begin
                        pc_enable = 1'b1;
                        reg_write = 1'b1;
                    end else begin
                        req_d   = 1'b1;
                        state_d = victim_dirty ? st_writeback : st_refill;
                    end
                end else if (ctrl.is_store) begin
                    if (victim_dirty) begin
                        req_d   = 1'b1;
                        state_d = st_writeback;
                    end else begin
                        // one word lines need no refill
                        cbus.we        = 1'b1;
                        cbus.set_dirty = 1'b1;
                        cbus.fill_sel  = 1'b1;
                        pc_enable      = 1'b1;
                    end
                end else begin
                    pc_enable = 1'b1;
                    reg_write = ctrl.reg_write;
                end
            end
            st_writeback: begin
                if (mbus.done) begin
                    req_d   = 1'b0;
                    state_d = ctrl.is_load ? st_refill : st_update;
                end
            end
            st_refill: begin
                // req low for one cycle after a writeback
                if (mbus.done) begin
                    req_d   = 1'b0;
                    state_d = st_update;
                end else begin
                    req_d = 1'b1;
                end
            end
            st_update: begin
                cbus.we   = 1'b1;
                pc_enable = 1'b1;
                state_d   = st_idle;
                if (ctrl.is_load) begin
                    reg_write = 1'b1;  // refilled line written clean
                end else begin
                    cbus.set_dirty = 1'b1;
                    cbus.fill_sel  = 1'b1;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            req_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            req_q   <= req_d;
        end
    end

    assign mbus.req = req_q;
    assign mbus.we  = (state_q == st_writeback);

endmodule

// ==== source/data_cache.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module data_cache (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`MIPS_DATA_W-1:0] addr,
    input  logic [`MIPS_DATA_W-1:0] store_data,
    cache_bus_if.cache              cbus,
    mem_bus_if.cache                mbus,
    output logic [`MIPS_DATA_W-1:0] load_data
);

    localparam int DW    = `MIPS_DATA_W;
    localparam int IDX_W = `MIPS_CACHE_IDX_W;
    localparam int LINES = 1 << IDX_W;
    localparam int TAG_W = DW - 2 - IDX_W;

    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;
    logic [TAG_W-1:0] tag_q [LINES];
    logic [DW-1:0]    data_q [LINES];

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [DW-1:0]    victim_addr;
    logic [DW-1:0]    wr_data;

    assign idx = addr[2 +: IDX_W];
    assign tag = addr[DW-1 -: TAG_W];

    assign cbus.hit   = valid_q[idx] && (tag_q[idx] == tag);
    assign cbus.dirty = valid_q[idx] && dirty_q[idx];

    assign victim_addr = {tag_q[idx], idx, 2'b00};
    assign mbus.addr   = mbus.we ? victim_addr : {addr[DW-1:2], 2'b00};
    assign mbus.wdata  = data_q[idx];

    assign wr_data   = cbus.fill_sel ? store_data : mbus.rdata;
    assign load_data = cbus.we ? wr_data : data_q[idx];  // refill bypass

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (cbus.we) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= cbus.set_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (cbus.we) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= wr_data;
        end
    end

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder import mips_pkg::*; (
    input  opcode_e opcode,
    input  func_e   func,
    output ctrl_t   ctrl
);

    always_comb begin
        // immediate alu row that writes nothing
        ctrl               = '0;
        ctrl.dest_sel      = dest_rt;
        ctrl.reg_src       = src_alu;
        ctrl.alu_op        = alu_add;
        ctrl.alu_src       = 1'b1;

        case (opcode)
            op_rtype: begin
                ctrl.dest_sel  = dest_rd;
                ctrl.alu_src   = 1'b0;
                ctrl.reg_write = 1'b1;
                case (func)
                    fn_xor:  ctrl.alu_op = alu_xor;
                    fn_sll:  ctrl.alu_op = alu_sll;
                    fn_sllv: ctrl.alu_op = alu_sllv;
                    fn_srl:  ctrl.alu_op = alu_srl;
                    fn_srlv: ctrl.alu_op = alu_srlv;
                    fn_sra:  ctrl.alu_op = alu_sra;
                    fn_add:  ctrl.alu_op = alu_add;
                    fn_addu: ctrl.alu_op = alu_add;
                    fn_sub:  ctrl.alu_op = alu_sub;
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_mult: ctrl.alu_op = alu_mult;
                    fn_div:  ctrl.alu_op = alu_div;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_nor:  ctrl.alu_op = alu_nor;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    fn_jr: begin
                        ctrl.alu_op        = alu_jr;
                        ctrl.jump_register = 1'b1;
                    end
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            op_addi: ctrl.reg_write = 1'b1;
            op_addiu: begin
                ctrl.reg_write   = 1'b1;
                ctrl.is_unsigned = 1'b1;
            end
            op_andi: begin
                ctrl.alu_op      = alu_and;
                ctrl.reg_write   = 1'b1;
                ctrl.is_unsigned = 1'b1;
            end
            op_xori: begin
                ctrl.alu_op      = alu_xor;
                ctrl.reg_write   = 1'b1;
                ctrl.is_unsigned = 1'b1;
            end
            op_ori: begin
                ctrl.alu_op      = alu_or;
                ctrl.reg_write   = 1'b1;
                ctrl.is_unsigned = 1'b1;
            end
            op_lw: begin
                ctrl.reg_src = src_mem;  // reg_write comes from cache_ctrl
                ctrl.is_load = 1'b1;
            end
            op_sw: ctrl.is_store = 1'b1;
            op_beq: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_beq;
            end
            op_bne: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_bne;
            end
            op_blez: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_blez;
            end
            op_bgtz: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_bgtz;
            end
            op_bgez: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_bgez;
            end
            op_slti: begin
                ctrl.alu_op    = alu_slt;
                ctrl.reg_write = 1'b1;
            end
            op_lui: begin
                ctrl.alu_op      = alu_lui;
                ctrl.reg_write   = 1'b1;
                ctrl.is_unsigned = 1'b1;
            end
            op_j: begin
                ctrl.jump    = 1'b1;
                ctrl.alu_src = 1'b0;
            end
            op_jal: begin
                ctrl.dest_sel  = dest_ra;
                ctrl.reg_src   = src_pc;
                ctrl.jump      = 1'b1;
                ctrl.alu_src   = 1'b0;
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl.alu_op    = alu_xor;
                ctrl.reg_write = 1'b1;
            end
        endcase
    end

endmodule

// ==== source/main_memory.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module main_memory (
    input  logic   clk,
    input  logic   rst_n,
    mem_bus_if.mem mbus
);

    localparam int DW    = `MIPS_DATA_W;
    localparam int WORDS = `MIPS_MEM_WORDS;
    localparam int AW    = $clog2(WORDS);
    localparam int CW    = $clog2(`MIPS_MEM_LAT + 1);

    logic [DW-1:0] mem_q [WORDS];
    logic [DW-1:0] rdata_q;
    logic [CW-1:0] cnt_q;
    logic          active_q;
    logic          done_q;
    logic [AW-1:0] word_addr;
    logic          fire;

    assign word_addr = mbus.addr[2 +: AW];
    assign fire      = active_q && (cnt_q == CW'(`MIPS_MEM_LAT - 1));

    // latency counter restarts only after req drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= fire;
            if (active_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (fire)
                    active_q <= 1'b0;
            end else if (mbus.req && !done_q) begin
                active_q <= 1'b1;
                cnt_q    <= CW'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WORDS; i++)
                mem_q[i] <= DW'(i) + `MIPS_MEM_FILL;
        end else if (fire && mbus.we) begin
            mem_q[word_addr] <= mbus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !mbus.we)
            rdata_q <= mem_q[word_addr];  // held until next read
    end

    assign mbus.rdata = rdata_q;
    assign mbus.done  = done_q;

endmodule

// ==== source/mem_bus_if.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

interface mem_bus_if;
    logic                    req;   // held until done
    logic                    we;
    logic [`MIPS_DATA_W-1:0] addr;  // byte address
    logic [`MIPS_DATA_W-1:0] wdata;
    logic [`MIPS_DATA_W-1:0] rdata;
    logic                    done;  // single cycle pulse

    modport ctrl (
        output req,
        output we,
        input  done
    );

    // we picks victim or requested address
    modport cache (
        input  we,
        input  rdata,
        output addr,
        output wdata
    );

    modport mem (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );
endinterface

// ==== source/mips_mem_top.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mips_mem_top import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  opcode_e                 opcode,
    input  func_e                   func,
    input  logic [`MIPS_DATA_W-1:0] addr,        // effective byte address
    input  logic [`MIPS_DATA_W-1:0] store_data,
    output ctrl_t                   ctrl,
    output logic                    pc_enable,
    output logic                    reg_write,
    output logic [`MIPS_DATA_W-1:0] load_data
);

    cache_bus_if cbus ();
    mem_bus_if   mbus ();

    instr_decoder u_decoder (
        .opcode (opcode),
        .func   (func),
        .ctrl   (ctrl)
    );

    cache_ctrl u_cache_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .cbus      (cbus.ctrl),
        .mbus      (mbus.ctrl),
        .pc_enable (pc_enable),
        .reg_write (reg_write)
    );

    data_cache u_data_cache (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .store_data (store_data),
        .cbus       (cbus.cache),
        .mbus       (mbus.cache),
        .load_data  (load_data)
    );

    main_memory u_main_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .mbus  (mbus.mem)
    );

endmodule

// ==== source/mips_pkg.sv ====
package mips_pkg;

    typedef enum logic [5:0] {
        op_rtype = 6'b000000,
        op_bgez  = 6'b000001,
        op_j     = 6'b000010,
        op_jal   = 6'b000011,
        op_beq   = 6'b000100,
        op_bne   = 6'b000101,
        op_blez  = 6'b000110,
        op_bgtz  = 6'b000111,
        op_addi  = 6'b001000,
        op_addiu = 6'b001001,
        op_slti  = 6'b001010,
        op_andi  = 6'b001100,
        op_ori   = 6'b001101,
        op_xori  = 6'b001110,
        op_lui   = 6'b001111,
        op_lw    = 6'b100011,
        op_sw    = 6'b101011
    } opcode_e;

    // r-type func field
    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,
        fn_srl  = 6'b000010,
        fn_sra  = 6'b000011,
        fn_sllv = 6'b000100,
        fn_srlv = 6'b000110,
        fn_jr   = 6'b001000,
        fn_mult = 6'b011000,
        fn_div  = 6'b011010,
        fn_add  = 6'b100000,
        fn_addu = 6'b100001,
        fn_sub  = 6'b100010,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_nor  = 6'b100111,
        fn_slt  = 6'b101010
    } func_e;

    typedef enum logic [4:0] {
        alu_xor  = 5'd0,
        alu_sll  = 5'd1,
        alu_srl  = 5'd2,
        alu_sra  = 5'd3,
        alu_add  = 5'd4,
        alu_sub  = 5'd5,
        alu_mult = 5'd6,
        alu_div  = 5'd7,
        alu_or   = 5'd8,
        alu_nor  = 5'd9,
        alu_and  = 5'd10,
        alu_slt  = 5'd11,
        alu_jr   = 5'd12,
        alu_beq  = 5'd13,
        alu_bne  = 5'd14,
        alu_blez = 5'd15,
        alu_bgtz = 5'd16,
        alu_bgez = 5'd17,
        alu_lui  = 5'd18,
        alu_sllv = 5'd25,
        alu_srlv = 5'd26
    } alu_op_e;

    typedef enum logic [1:0] {
        dest_rt = 2'b00,
        dest_rd = 2'b01,
        dest_ra = 2'b10  // link register for jal
    } dest_sel_e;

    typedef enum logic [1:0] {
        src_alu = 2'b00,
        src_mem = 2'b01,
        src_pc  = 2'b10
    } reg_src_e;

    typedef struct packed {
        dest_sel_e dest_sel;
        reg_src_e  reg_src;
        alu_op_e   alu_op;
        logic      alu_src;  // 1 selects the immediate
        logic      jump;
        logic      branch;
        logic      jump_register;
        logic      is_unsigned;
        logic      reg_write;
        logic      is_load;
        logic      is_store;
    } ctrl_t;

endpackage

// ==== verif/tb_mips_mem.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module tb_mips_mem import mips_pkg::*; ();

    localparam int DW  = `MIPS_DATA_W;
    localparam int AW  = $clog2(`MIPS_MEM_WORDS);
    localparam int RST = 16;

    typedef struct {
        opcode_e       op;
        func_e         fn;
        logic [DW-1:0] addr;
        logic [DW-1:0] sdata;
        ctrl_t         exp_ctrl;
        logic [DW-1:0] exp_data;
        bit            one_cycle;  // done in the cycle it is presented
    } row_t;

    logic          clk;
    logic          rst_n;
    opcode_e       opcode;
    func_e         func;
    logic [DW-1:0] addr;
    logic [DW-1:0] store_data;
    ctrl_t         ctrl;
    logic          pc_enable;
    logic          reg_write;
    logic [DW-1:0] load_data;

    row_t          rows[$];
    logic [DW-1:0] model_mem [`MIPS_MEM_WORDS];  // backing store as seen by the program
    int            cycles;
    int            cycle_limit;

    mips_mem_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .func       (func),
        .addr       (addr),
        .store_data (store_data),
        .ctrl       (ctrl),
        .pc_enable  (pc_enable),
        .reg_write  (reg_write),
        .load_data  (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s ctrl got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // flag order alu_src jump branch jump_register is_unsigned reg_write is_load is_store
    function automatic ctrl_t make_ctrl(dest_sel_e d, reg_src_e s, alu_op_e a,
                                        logic [7:0] flags);
        ctrl_t c;
        c.dest_sel = d;
        c.reg_src  = s;
        c.alu_op   = a;
        {c.alu_src, c.jump, c.branch, c.jump_register,
         c.is_unsigned, c.reg_write, c.is_load, c.is_store} = flags;
        return c;
    endfunction

    function automatic ctrl_t rtype_ctrl(alu_op_e a);
        return make_ctrl(dest_rd, src_alu, a, 8'b0000_0100);
    endfunction

    task automatic add_row(input opcode_e op, input func_e fn, input ctrl_t c);
        row_t r;
        r.op        = op;
        r.fn        = fn;
        r.addr      = '0;
        r.sdata     = '0;
        r.exp_ctrl  = c;
        r.exp_data  = '0;
        r.one_cycle = 1'b1;
        rows.push_back(r);
    endtask

    // memory access with expected data from the model
    task automatic add_mem(input logic is_st, input logic [DW-1:0] a,
                           input logic [DW-1:0] d, input bit hit);
        row_t r;
        r.op        = is_st ? op_sw : op_lw;
        r.fn        = fn_sll;
        r.addr      = a;
        r.sdata     = d;
        r.exp_ctrl  = is_st ? make_ctrl(dest_rt, src_alu, alu_add, 8'b1000_0001)
                            : make_ctrl(dest_rt, src_mem, alu_add, 8'b1000_0010);
        if (is_st)
            model_mem[a[2 +: AW]] = d;
        r.exp_data  = model_mem[a[2 +: AW]];
        r.one_cycle = hit;
        rows.push_back(r);
    endtask

    task automatic build_table();
        int unsigned words [5] = '{4, 20, 36, 5, 21};  // two indices and several tags
        for (int i = 0; i < `MIPS_MEM_WORDS; i++)
            model_mem[i] = DW'(i) + `MIPS_MEM_FILL;
        add_row(op_rtype, fn_sll,  rtype_ctrl(alu_sll));
        add_row(op_rtype, fn_srl,  rtype_ctrl(alu_srl));
        add_row(op_rtype, fn_sra,  rtype_ctrl(alu_sra));
        add_row(op_rtype, fn_sllv, rtype_ctrl(alu_sllv));
        add_row(op_rtype, fn_srlv, rtype_ctrl(alu_srlv));
        add_row(op_rtype, fn_mult, rtype_ctrl(alu_mult));
        add_row(op_rtype, fn_div,  rtype_ctrl(alu_div));
        add_row(op_rtype, fn_add,  rtype_ctrl(alu_add));
        add_row(op_rtype, fn_addu, rtype_ctrl(alu_add));
        add_row(op_rtype, fn_sub,  rtype_ctrl(alu_sub));
        add_row(op_rtype, fn_subu, rtype_ctrl(alu_sub));
        add_row(op_rtype, fn_and,  rtype_ctrl(alu_and));
        add_row(op_rtype, fn_or,   rtype_ctrl(alu_or));
        add_row(op_rtype, fn_xor,  rtype_ctrl(alu_xor));
        add_row(op_rtype, fn_nor,  rtype_ctrl(alu_nor));
        add_row(op_rtype, fn_slt,  rtype_ctrl(alu_slt));
        add_row(op_rtype, fn_jr,   make_ctrl(dest_rd, src_alu, alu_jr, 8'b0001_0100));
        add_row(op_addi,  fn_sll,  make_ctrl(dest_rt, src_alu, alu_add,  8'b1000_0100));
        add_row(op_addiu, fn_sll,  make_ctrl(dest_rt, src_alu, alu_add,  8'b1000_1100));
        add_row(op_andi,  fn_sll,  make_ctrl(dest_rt, src_alu, alu_and,  8'b1000_1100));
        add_row(op_xori,  fn_sll,  make_ctrl(dest_rt, src_alu, alu_xor,  8'b1000_1100));
        add_row(op_ori,   fn_sll,  make_ctrl(dest_rt, src_alu, alu_or,   8'b1000_1100));
        add_row(op_lui,   fn_sll,  make_ctrl(dest_rt, src_alu, alu_lui,  8'b1000_1100));
        add_row(op_slti,  fn_sll,  make_ctrl(dest_rt, src_alu, alu_slt,  8'b1000_0100));
        add_row(op_beq,   fn_sll,  make_ctrl(dest_rt, src_alu, alu_beq,  8'b1010_0000));
        add_row(op_bne,   fn_sll,  make_ctrl(dest_rt, src_alu, alu_bne,  8'b1010_0000));
        add_row(op_blez,  fn_sll,  make_ctrl(dest_rt, src_alu, alu_blez, 8'b1010_0000));
        add_row(op_bgtz,  fn_sll,  make_ctrl(dest_rt, src_alu, alu_bgtz, 8'b1010_0000));
        add_row(op_bgez,  fn_sll,  make_ctrl(dest_rt, src_alu, alu_bgez, 8'b1010_0000));
        add_row(op_j,     fn_sll,  make_ctrl(dest_rt, src_alu, alu_add,  8'b0100_0000));
        add_row(op_jal,   fn_sll,  make_ctrl(dest_ra, src_pc,  alu_add,  8'b0100_0100));
        add_mem(1'b0, 32'h10, '0, 1'b0);            // clean miss
        add_mem(1'b0, 32'h10, '0, 1'b1);            // same word again, hit
        add_mem(1'b1, 32'h24, 32'hdead_beef, 1'b1); // store miss into an empty line
        add_mem(1'b0, 32'h24, '0, 1'b1);
        add_mem(1'b1, 32'h10, 32'ha5a5_0010, 1'b1);
        add_mem(1'b1, 32'h50, 32'h5a5a_0050, 1'b0); // same index, evicts 0x10
        add_mem(1'b0, 32'h10, '0, 1'b0);            // writeback then refill
        add_mem(1'b0, 32'h50, '0, 1'b0);
        for (int i = 0; i < 24; i++)
            add_mem(1'($urandom % 2), DW'(words[$urandom % 5] * 4), $urandom, 1'b0);
    endtask

    // watchdog
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycle_limit > 0 && cycles >= cycle_limit) begin
                $display("timeout after %0d cycles, pc_enable never came", cycles);
                abort_run();
            end
        end
    end

    initial begin
        int   waited;
        logic exp_rw;
        row_t r;
        rst_n       = 1'b0;
        opcode      = op_beq;
        func        = fn_sll;
        addr        = '0;
        store_data  = '0;
        cycle_limit = 0;
        void'($urandom(15182));
        build_table();
        cycle_limit = rows.size() * (2 * `MIPS_MEM_LAT + 4) + RST;

        repeat (RST) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_flag(reg_write, 1'b0, "reg_write after reset");
        compare_flag(dut0.mbus.req, 1'b0, "mem_req after reset");
        compare_flag(dut0.cbus.we, 1'b0, "cache write enable after reset");

        @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            opcode     <= r.op;
            func       <= r.fn;
            addr       <= r.addr;
            store_data <= r.sdata;
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (pc_enable !== 1'b1);
            exp_rw = r.exp_ctrl.is_load ? 1'b1 :
                     r.exp_ctrl.is_store ? 1'b0 : r.exp_ctrl.reg_write;
            check_ctrl(ctrl, r.exp_ctrl, $sformatf("row %0d", i));
            compare_flag(reg_write, exp_rw, $sformatf("row %0d reg_write", i));
            if (r.exp_ctrl.is_load)
                check_word(load_data, r.exp_data, $sformatf("row %0d load_data", i));
            if (r.one_cycle)
                compare_flag(waited == 1, 1'b1, $sformatf("row %0d done in first cycle", i));
            @(posedge clk);  // instruction retires on this edge
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule
